// File: Bender.yml
package:
  name: board_ctrl

sources:
  # RTL in compile order
  - files:
      - source/board_ctrl_pkg.sv
      - source/board_req_if.sv
      - source/board_reg_decode.sv
      - source/board_event_sync.sv
      - source/board_ctrl_regs.sv
      - source/board_read_result.sv
      - source/board_ctrl_top.sv

  # Testbench
  - target: simulation
    files:
      - bench/board_ctrl_assert.sv
      - bench/board_ctrl_checker.sv
      - bench/board_ctrl_tb.sv

// File: bench/board_ctrl_assert.sv
/*
  Wishbone response assertions
  Bound into the read result stage of the board control block
*/
module board_ctrl_assert (
  input logic bus_clk,
  input logic bus_rst,
  input logic req_valid,
  input logic req_hit,
  input logic wb_ack,
  input logic wb_err
);
  timeunit 1ns;
  timeprecision 100ps;

  // Only one kind of response at a time
  ack_err_excl: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(wb_ack && wb_err))
    else $error("wb_ack and wb_err high in the same cycle");

  ack_one_cycle: assert property (@(posedge bus_clk) disable iff (bus_rst)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held longer than one cycle");

  // A mapped request is acknowledged on the next edge
  req_then_ack: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (req_valid && req_hit) |=> wb_ack)
    else $error("no wb_ack one cycle after a request");

endmodule

bind board_read_result board_ctrl_assert board_ctrl_assert_inst (
  .bus_clk   (bus_clk),
  .bus_rst   (bus_rst),
  .req_valid (req.req_valid),
  .req_hit   (req.req_hit),
  .wb_ack    (wb_ack),
  .wb_err    (wb_err)
);

// File: bench/board_ctrl_checker.sv
/*
  Board control checker
  Compares bus responses, front-end pins and irq with expected values
*/
module board_ctrl_checker (
  input  logic        bus_clk,
  input  logic        bus_rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic [31:0] wb_dat_r,
  input  logic        wb_ack,
  input  logic        wb_err,
  input  logic [16:0] bandsel,
  input  logic [11:0] rf_enable,
  input  logic [5:0]  led,
  input  logic [5:0]  gpio,
  input  logic        irq,
  input  logic [31:0] exp_dat,
  input  logic        check_dat,
  input  logic        exp_err,
  input  logic [16:0] exp_bandsel,
  input  logic [11:0] exp_rf_enable,
  input  logic [5:0]  exp_led,
  input  logic [5:0]  exp_gpio,
  input  logic        exp_irq,
  input  logic        row_end,
  input  int          row_num,
  output int          check_count,
  output int          fail_count
);
  timeunit 1ns;
  timeprecision 100ps;

  logic busy;
  int   lat;
  int   row_fails;

  initial begin
    check_count = 0;
    fail_count  = 0;
    row_fails   = 0;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      fail_count++;
      row_fails++;
      $display("mismatch t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
    end
  endtask

  task automatic report_failure(input string what);
    fail_count++;
    row_fails++;
    $display("error t=%0t %s", $time, what);
  endtask

  //----------------------------------------------------------------------
  // Values seen here are the ones settled before the edge
  //----------------------------------------------------------------------
  always @(posedge bus_clk) begin
    if (bus_rst) begin
      busy = 1'b0;
      lat  = 0;
    end else if (busy) begin
      if (wb_ack || wb_err) begin
        busy = 1'b0;
        // lat counts edges after the first strobe sample up to the response edge
        check_count++;
        if (lat != 2) begin
          report_failure($sformatf("response came %0d cycles after the strobe, not 2", lat));
        end
        compare_value("wb_err", 32'(wb_err), 32'(exp_err));
        if (check_dat) begin
          compare_value("wb_dat_r", wb_dat_r, exp_dat);
        end
        compare_value("bandsel pins", 32'(bandsel), 32'(exp_bandsel));
        compare_value("rf_enable pins", 32'(rf_enable), 32'(exp_rf_enable));
        compare_value("led", 32'(led), 32'(exp_led));
        compare_value("pl_gpio", 32'(gpio), 32'(exp_gpio));
      end else begin
        lat++;
      end
    end else if (wb_ack || wb_err) begin
      report_failure("bus response without a strobe");
    end else if (wb_cyc && wb_stb) begin
      busy = 1'b1;
      lat  = 0;
    end

    if (row_end) begin
      compare_value("irq", 32'(irq), 32'(exp_irq));
      if (row_fails == 0) begin
        $display("row %0d: pass", row_num);
      end else begin
        $display("row %0d: %0d failed checks", row_num, row_fails);
      end
      row_fails = 0;
    end
  end

endmodule

// File: bench/board_ctrl_tb.sv
/*
  Board control testbench
  Table-driven Wishbone accesses and input events against the register block
*/
module board_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import board_ctrl_pkg::*;

  typedef enum int {k_wr, k_rd, k_press, k_release, k_pps} row_kind_t;

  logic        bus_clk = 1'b0;
  logic        bus_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  reg_idx_t    wb_adr;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        onswitch_n;
  logic        gps_pps;
  logic [2:0]  tx_bandsel;
  logic [2:0]  rx1_bandsel;
  logic [2:0]  rx2_bandsel;
  logic [1:0]  rx1b_bandsel;
  logic [1:0]  rx1c_bandsel;
  logic [1:0]  rx2b_bandsel;
  logic [1:0]  rx2c_bandsel;
  logic [3:0]  tx_enable;
  logic [7:0]  ant_sel;
  logic [5:0]  led;
  logic [5:0]  pl_gpio;
  logic        irq;

  // Expected values handed to the checker
  logic [31:0] exp_dat;
  logic        check_dat;
  logic        exp_err;
  logic        exp_irq;
  logic [16:0] exp_bandsel;
  logic [11:0] exp_rf_enable;
  logic [5:0]  exp_led;
  logic [5:0]  exp_gpio;
  logic        row_end;
  int          row_num;
  int          check_count;
  int          fail_count;
  bit          rows_loaded = 1'b0;

  // Stimulus table, one entry per row
  row_kind_t   t_kind[$];
  reg_idx_t    t_idx[$];
  logic [3:0]  t_sel[$];
  logic [31:0] t_data[$];
  logic [31:0] t_exp[$];
  logic        t_err[$];
  logic        t_irq[$];

  // Register contents as the bench expects them
  logic [bandsel_w-1:0]   sh_bandsel = '0;
  logic [rf_enable_w-1:0] sh_rf_enable = '0;
  logic [led_w-1:0]       sh_led = '0;
  logic [gpio_w-1:0]      sh_gpio = '0;
  logic [31:0]            sh_scratch = '0;
  logic [31:0]            rng = 32'd27182;

  always #2 bus_clk = ~bus_clk;

  board_ctrl_top board_ctrl_top_inst (.*);

  board_ctrl_checker board_ctrl_checker_inst (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .wb_err        (wb_err),
    .bandsel       ({rx2c_bandsel, rx2b_bandsel, rx1c_bandsel, rx1b_bandsel,
                     rx2_bandsel, rx1_bandsel, tx_bandsel}),
    .rf_enable     ({ant_sel, tx_enable}),
    .led           (led),
    .gpio          (pl_gpio),
    .irq           (irq),
    .exp_dat       (exp_dat),
    .check_dat     (check_dat),
    .exp_err       (exp_err),
    .exp_bandsel   (exp_bandsel),
    .exp_rf_enable (exp_rf_enable),
    .exp_led       (exp_led),
    .exp_gpio      (exp_gpio),
    .exp_irq       (exp_irq),
    .row_end       (row_end),
    .row_num       (row_num),
    .check_count   (check_count),
    .fail_count    (fail_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Byte lanes with sel set take the new data
  function automatic logic [31:0] merge_sel(input logic [31:0] cur, input logic [31:0] wdata,
                                            input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (cur & ~mask) | (wdata & mask);
  endfunction

  task automatic update_shadow(input reg_idx_t idx, input logic [3:0] sel,
                               input logic [31:0] data);
    case (idx)
      reg_bandsel:   sh_bandsel   = bandsel_w'(merge_sel(32'(sh_bandsel), data, sel));
      reg_rf_enable: sh_rf_enable = rf_enable_w'(merge_sel(32'(sh_rf_enable), data, sel));
      reg_led:       sh_led       = led_w'(merge_sel(32'(sh_led), data, sel));
      reg_gpio:      sh_gpio      = gpio_w'(merge_sel(32'(sh_gpio), data, sel));
      reg_scratch:   sh_scratch   = merge_sel(sh_scratch, data, sel);
      default: ;
    endcase
  endtask

  task automatic add_row(input row_kind_t kind, input reg_idx_t idx, input logic [3:0] sel,
                         input logic [31:0] data, input logic [31:0] exp,
                         input logic err, input logic irq_exp);
    t_kind.push_back(kind);
    t_idx.push_back(idx);
    t_sel.push_back(sel);
    t_data.push_back(data);
    t_exp.push_back(exp);
    t_err.push_back(err);
    t_irq.push_back(irq_exp);
  endtask

  //----------------------------------------------------------------------
  // Stimulus table
  //----------------------------------------------------------------------
  task automatic build_table();
    // kind       idx             sel    data          exp           err   irq
    // Reset values
    add_row(k_rd,      reg_id,         4'hf, 32'h0,        board_id,     1'b0, 1'b0);
    add_row(k_rd,      reg_bandsel,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_rf_enable,  4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_led,        4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_irq_status, 4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_irq_mask,   4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_gpio,       4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_scratch,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    // Byte-select writes, scratch data comes from xorshift
    add_row(k_wr,      reg_bandsel,    4'hf, 32'h0001abcd, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_bandsel,    4'hf, 32'h0,        32'h0001abcd, 1'b0, 1'b0);
    add_row(k_wr,      reg_bandsel,    4'h2, 32'hffff12ff, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_bandsel,    4'hf, 32'h0,        32'h000112cd, 1'b0, 1'b0);
    add_row(k_wr,      reg_rf_enable,  4'h1, 32'h000000a5, 32'h0,        1'b0, 1'b0);
    add_row(k_wr,      reg_rf_enable,  4'h2, 32'h00000f00, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_rf_enable,  4'hf, 32'h0,        32'h00000fa5, 1'b0, 1'b0);
    add_row(k_wr,      reg_led,        4'h1, 32'hffffffea, 32'h0,        1'b0, 1'b0);
    add_row(k_wr,      reg_led,        4'he, 32'h00000000, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_led,        4'hf, 32'h0,        32'h0000002a, 1'b0, 1'b0);
    add_row(k_wr,      reg_gpio,       4'h1, 32'h00000015, 32'h0,        1'b0, 1'b0);
    add_row(k_wr,      reg_gpio,       4'he, 32'hffffff00, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_gpio,       4'hf, 32'h0,        32'h00000015, 1'b0, 1'b0);
    add_row(k_wr,      reg_scratch,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_scratch,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_wr,      reg_scratch,    4'h5, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_scratch,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_wr,      reg_scratch,    4'ha, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_scratch,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
    // Button events with press and release unmasked
    add_row(k_wr,      reg_irq_mask,   4'h1, 32'h00000003, 32'h0,        1'b0, 1'b0);
    add_row(k_press,   reg_id,         4'h0, 32'h0,        32'h0,        1'b0, 1'b1);
    add_row(k_rd,      reg_irq_status, 4'hf, 32'h0,        32'h00000001, 1'b0, 1'b1);
    add_row(k_release, reg_id,         4'h0, 32'h0,        32'h0,        1'b0, 1'b1);
    add_row(k_rd,      reg_irq_status, 4'hf, 32'h0,        32'h00000003, 1'b0, 1'b1);
    add_row(k_wr,      reg_irq_status, 4'h1, 32'h00000003, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_irq_status, 4'hf, 32'h0,        32'h00000000, 1'b0, 1'b0);
    add_row(k_rd,      reg_irq_mask,   4'hf, 32'h0,        32'h00000003, 1'b0, 1'b0);
    // PPS with everything masked, data bit 0 is the input level
    add_row(k_wr,      reg_irq_mask,   4'h1, 32'h00000000, 32'h0,        1'b0, 1'b0);
    add_row(k_pps,     reg_id,         4'h0, 32'h1,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_irq_status, 4'hf, 32'h0,        32'h00000104, 1'b0, 1'b0);
    add_row(k_pps,     reg_id,         4'h0, 32'h0,        32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_irq_status, 4'hf, 32'h0,        32'h00000004, 1'b0, 1'b0);
    // Unmapped indices and the read-only ID
    add_row(k_rd,      6'd8,           4'hf, 32'h0,        32'h0,        1'b1, 1'b0);
    add_row(k_wr,      6'd63,          4'hf, 32'hffffffff, 32'h0,        1'b1, 1'b0);
    add_row(k_wr,      reg_id,         4'hf, 32'hffffffff, 32'h0,        1'b0, 1'b0);
    add_row(k_rd,      reg_id,         4'hf, 32'h0,        board_id,     1'b0, 1'b0);
    add_row(k_rd,      reg_bandsel,    4'hf, 32'h0,        32'h000112cd, 1'b0, 1'b0);
    add_row(k_rd,      reg_scratch,    4'hf, 32'h0,        32'h0,        1'b0, 1'b0);
  endtask

  // One Wishbone classic transfer, strobe held until the response
  task automatic bus_access(input logic we, input reg_idx_t idx, input logic [3:0] sel,
                            input logic [31:0] data);
    @(posedge bus_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= idx;
    wb_sel   <= sel;
    wb_dat_w <= data;
    do begin
      @(posedge bus_clk);
    end while (!(wb_ack || wb_err));
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic set_event_inputs(input logic sw_n, input logic pps);
    @(posedge bus_clk);
    onswitch_n <= sw_n;
    gps_pps    <= pps;
    repeat (10) @(posedge bus_clk);
  endtask

  task automatic finish_row(input int n);
    @(posedge bus_clk);
    row_num <= n;
    row_end <= 1'b1;
    @(posedge bus_clk);
    row_end <= 1'b0;
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] data;
    logic [31:0] exp;
    bus_rst    = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_sel     = '0;
    wb_dat_w   = '0;
    onswitch_n = 1'b1;
    gps_pps    = 1'b0;
    exp_dat    = '0;
    check_dat  = 1'b0;
    exp_err    = 1'b0;
    exp_irq    = 1'b0;
    exp_bandsel   = '0;
    exp_rf_enable = '0;
    exp_led    = '0;
    exp_gpio   = '0;
    row_end    = 1'b0;
    row_num    = 0;
    build_table();
    rows_loaded = 1'b1;

    repeat (16) @(posedge bus_clk);
    bus_rst <= 1'b0;

    for (int r = 0; r < t_kind.size(); r++) begin
      data = t_data[r];
      exp  = t_exp[r];
      if (t_kind[r] == k_wr && t_idx[r] == reg_scratch) begin
        rng  = xorshift32(rng);
        data = rng;
      end
      if (t_kind[r] == k_wr && !t_err[r]) begin
        update_shadow(t_idx[r], t_sel[r], data);
      end
      if (t_kind[r] == k_rd && t_idx[r] == reg_scratch) begin
        exp = sh_scratch;
      end
      exp_dat       <= exp;
      check_dat     <= (t_kind[r] == k_rd) || t_err[r];
      exp_err       <= t_err[r];
      exp_irq       <= t_irq[r];
      exp_bandsel   <= sh_bandsel;
      exp_rf_enable <= sh_rf_enable;
      exp_led       <= sh_led;
      exp_gpio      <= sh_gpio;
      case (t_kind[r])
        k_wr:      bus_access(1'b1, t_idx[r], t_sel[r], data);
        k_rd:      bus_access(1'b0, t_idx[r], t_sel[r], data);
        k_press:   set_event_inputs(1'b0, gps_pps);
        k_release: set_event_inputs(1'b1, gps_pps);
        default:   set_event_inputs(onswitch_n, data[0]);
      endcase
      finish_row(r);
    end

    repeat (2) @(posedge bus_clk);
    $display("%0d rows, %0d checks, %0d errors", t_kind.size(), check_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Budget of 40 cycles per row on top of reset
  initial begin : watchdog
    int limit;
    wait (rows_loaded);
    limit = t_kind.size() * 40 + 16;
    repeat (limit) @(posedge bus_clk);
    $display("run timed out after %0d cycles without finishing the table", limit);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: sim.f
source/board_ctrl_pkg.sv
source/board_req_if.sv
source/board_reg_decode.sv
source/board_event_sync.sv
source/board_ctrl_regs.sv
source/board_read_result.sv
source/board_ctrl_top.sv
bench/board_ctrl_assert.sv
bench/board_ctrl_checker.sv
bench/board_ctrl_tb.sv

// File: source/board_ctrl_pkg.sv
/*
  Board control package
  Register map, field widths, status bit positions and reset values
*/
package board_ctrl_pkg;

  // Word address on the bus
  typedef logic [5:0] reg_idx_t;

  localparam int num_regs = 8;

  //----------------------------------------------------------------------
  // Register indices
  //----------------------------------------------------------------------
  localparam reg_idx_t reg_id         = 6'd0;
  localparam reg_idx_t reg_bandsel    = 6'd1;
  localparam reg_idx_t reg_rf_enable  = 6'd2;
  localparam reg_idx_t reg_led        = 6'd3;
  localparam reg_idx_t reg_irq_status = 6'd4;
  localparam reg_idx_t reg_irq_mask   = 6'd5;
  localparam reg_idx_t reg_gpio       = 6'd6;
  localparam reg_idx_t reg_scratch    = 6'd7;

  // Read-only board identifier
  localparam logic [31:0] board_id = 32'h5344_5201;

  //----------------------------------------------------------------------
  // Field widths
  //----------------------------------------------------------------------
  // tx, rx1, rx2, rx1b, rx1c, rx2b, rx2c from bit 0 upward
  localparam int bandsel_w   = 17;
  // tx enables in 3:0, antenna selects in 11:4
  localparam int rf_enable_w = 12;
  localparam int led_w       = 6;
  localparam int gpio_w      = 6;

  // Status bits
  localparam int num_evt     = 3;
  localparam int evt_press   = 0;
  localparam int evt_release = 1;
  localparam int evt_pps     = 2;
  localparam int pps_level   = 8;

  // Reset values
  localparam logic [bandsel_w-1:0]   bandsel_rst   = '0;
  localparam logic [rf_enable_w-1:0] rf_enable_rst = '0;
  localparam logic [led_w-1:0]       led_rst       = '0;
  localparam logic [gpio_w-1:0]      gpio_rst      = '0;
  localparam logic [num_evt-1:0]     irq_mask_rst  = '0;
  localparam logic [31:0]            scratch_rst   = '0;

endpackage

// File: source/board_ctrl_regs.sv
/*
  Control and status registers
  Byte-selected writes, sticky event status and the masked interrupt
*/
module board_ctrl_regs (
  input  logic                                     bus_clk,
  input  logic                                     bus_rst,
  board_req_if.exec                                req,
  input  logic                                     press,
  input  logic                                     release_evt,
  input  logic                                     pps_edge,
  output logic [board_ctrl_pkg::bandsel_w-1:0]     bandsel,
  output logic [board_ctrl_pkg::rf_enable_w-1:0]   rf_enable,
  output logic [board_ctrl_pkg::led_w-1:0]         led,
  output logic [board_ctrl_pkg::gpio_w-1:0]        gpio,
  output logic [board_ctrl_pkg::num_evt-1:0]       irq_status,
  output logic [board_ctrl_pkg::num_evt-1:0]       irq_mask,
  output logic [31:0]                              scratch,
  output logic                                     irq
);
  import board_ctrl_pkg::*;

  logic               wr;
  logic [num_evt-1:0] evt;
  logic [num_evt-1:0] clr;

  // Replace only the bytes with sel set
  function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr = req.req_valid & req.req_we & req.req_hit;

  //----------------------------------------------------------------------
  // Writable registers
  //----------------------------------------------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      bandsel   <= bandsel_rst;
      rf_enable <= rf_enable_rst;
      led       <= led_rst;
      gpio      <= gpio_rst;
      irq_mask  <= irq_mask_rst;
      scratch   <= scratch_rst;
    end else if (wr) begin
      case (req.req_idx)
        reg_bandsel:
          bandsel <= bandsel_w'(merge_bytes(32'(bandsel), req.req_wdata, req.req_sel));
        reg_rf_enable:
          rf_enable <= rf_enable_w'(merge_bytes(32'(rf_enable), req.req_wdata, req.req_sel));
        reg_led:
          led <= led_w'(merge_bytes(32'(led), req.req_wdata, req.req_sel));
        reg_gpio:
          gpio <= gpio_w'(merge_bytes(32'(gpio), req.req_wdata, req.req_sel));
        reg_irq_mask:
          irq_mask <= num_evt'(merge_bytes(32'(irq_mask), req.req_wdata, req.req_sel));
        reg_scratch:
          scratch <= merge_bytes(scratch, req.req_wdata, req.req_sel);
        // ID and status are not plain writes
        default: ;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Sticky status, write one to clear
  //----------------------------------------------------------------------
  assign evt[evt_press]   = press;
  assign evt[evt_release] = release_evt;
  assign evt[evt_pps]     = pps_edge;

  assign clr = (wr && req.req_idx == reg_irq_status && req.req_sel[0]) ?
               req.req_wdata[num_evt-1:0] : '0;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      irq_status <= '0;
      irq        <= 1'b0;
    end else begin
      // A new event beats a clear in the same cycle
      irq_status <= evt | (irq_status & ~clr);
      irq        <= |(irq_status & irq_mask);
    end
  end

endmodule

// File: source/board_ctrl_top.sv
/*
  Board control top level
  Wishbone register block driving the radio front-end pins
*/
module board_ctrl_top (
  input  logic                     bus_clk,
  input  logic                     bus_rst,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  board_ctrl_pkg::reg_idx_t wb_adr,
  input  logic [3:0]               wb_sel,
  input  logic [31:0]              wb_dat_w,
  output logic [31:0]              wb_dat_r,
  output logic                     wb_ack,
  output logic                     wb_err,
  input  logic                     onswitch_n,
  input  logic                     gps_pps,
  output logic [2:0]               tx_bandsel,
  output logic [2:0]               rx1_bandsel,
  output logic [2:0]               rx2_bandsel,
  output logic [1:0]               rx1b_bandsel,
  output logic [1:0]               rx1c_bandsel,
  output logic [1:0]               rx2b_bandsel,
  output logic [1:0]               rx2c_bandsel,
  output logic [3:0]               tx_enable,
  output logic [7:0]               ant_sel,
  output logic [5:0]               led,
  output logic [5:0]               pl_gpio,
  output logic                     irq
);
  import board_ctrl_pkg::*;

  logic [bandsel_w-1:0]   bandsel;
  logic [rf_enable_w-1:0] rf_enable;
  logic [num_evt-1:0]     irq_status;
  logic [num_evt-1:0]     irq_mask;
  logic [31:0]            scratch;
  logic                   press;
  logic                   release_evt;
  logic                   pps_edge;
  logic                   pps_sync;

  board_req_if req_if ();

  board_reg_decode board_reg_decode_inst (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_w (wb_dat_w),
    .req      (req_if.decode)
  );

  board_event_sync board_event_sync_inst (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .onswitch_n  (onswitch_n),
    .gps_pps     (gps_pps),
    .press       (press),
    .release_evt (release_evt),
    .pps_edge    (pps_edge),
    .pps_sync    (pps_sync)
  );

  board_ctrl_regs board_ctrl_regs_inst (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .req         (req_if.exec),
    .press       (press),
    .release_evt (release_evt),
    .pps_edge    (pps_edge),
    .bandsel     (bandsel),
    .rf_enable   (rf_enable),
    .led         (led),
    .gpio        (pl_gpio),
    .irq_status  (irq_status),
    .irq_mask    (irq_mask),
    .scratch     (scratch),
    .irq         (irq)
  );

  board_read_result board_read_result_inst (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .req        (req_if.result),
    .bandsel    (bandsel),
    .rf_enable  (rf_enable),
    .led        (led),
    .gpio       (pl_gpio),
    .irq_status (irq_status),
    .irq_mask   (irq_mask),
    .scratch    (scratch),
    .pps_sync   (pps_sync),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err)
  );

  //----------------------------------------------------------------------
  // Front-end pin fields
  //----------------------------------------------------------------------
  assign tx_bandsel   = bandsel[2:0];
  assign rx1_bandsel  = bandsel[5:3];
  assign rx2_bandsel  = bandsel[8:6];
  assign rx1b_bandsel = bandsel[10:9];
  assign rx1c_bandsel = bandsel[12:11];
  assign rx2b_bandsel = bandsel[14:13];
  assign rx2c_bandsel = bandsel[16:15];

  assign tx_enable    = rf_enable[3:0];
  assign ant_sel      = rf_enable[11:4];

endmodule

// File: source/board_event_sync.sv
/*
  Event synchronizers
  Power button press and release edges, GPS PPS rising edge and level
*/
module board_event_sync (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_n,
  input  logic gps_pps,
  output logic press,
  output logic release_evt,
  output logic pps_edge,
  output logic pps_sync
);

  // Stages 0 and 1 synchronize, stage 2 holds the previous level
  logic [2:0] sw_sr;
  logic [2:0] pps_sr;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      // Button idles released, input is active low
      sw_sr  <= 3'b111;
      pps_sr <= 3'b000;
    end else begin
      sw_sr  <= {sw_sr[1:0], onswitch_n};
      pps_sr <= {pps_sr[1:0], gps_pps};
    end
  end

  //----------------------------------------------------------------------
  // Edge pulses, one cycle each
  //----------------------------------------------------------------------
  // Press is high to low
  assign press       = sw_sr[2] & ~sw_sr[1];
  assign release_evt = ~sw_sr[2] & sw_sr[1];

  assign pps_edge    = ~pps_sr[2] & pps_sr[1];

  // Live level for the status read
  assign pps_sync    = pps_sr[1];

endmodule

// File: source/board_read_result.sv
/*
  Read data and bus response
  Registers the addressed word with ack, or zero data with err
*/
module board_read_result (
  input  logic                                   bus_clk,
  input  logic                                   bus_rst,
  board_req_if.result                            req,
  input  logic [board_ctrl_pkg::bandsel_w-1:0]   bandsel,
  input  logic [board_ctrl_pkg::rf_enable_w-1:0] rf_enable,
  input  logic [board_ctrl_pkg::led_w-1:0]       led,
  input  logic [board_ctrl_pkg::gpio_w-1:0]      gpio,
  input  logic [board_ctrl_pkg::num_evt-1:0]     irq_status,
  input  logic [board_ctrl_pkg::num_evt-1:0]     irq_mask,
  input  logic [31:0]                            scratch,
  input  logic                                   pps_sync,
  output logic [31:0]                            wb_dat_r,
  output logic                                   wb_ack,
  output logic                                   wb_err
);
  import board_ctrl_pkg::*;

  logic [31:0] rd_data;

  // Zero-extended read mux
  always_comb begin
    rd_data = '0;
    case (req.req_idx)
      reg_id:         rd_data = board_id;
      reg_bandsel:    rd_data[bandsel_w-1:0] = bandsel;
      reg_rf_enable:  rd_data[rf_enable_w-1:0] = rf_enable;
      reg_led:        rd_data[led_w-1:0] = led;
      reg_irq_status: begin
        rd_data[num_evt-1:0] = irq_status;
        rd_data[pps_level]   = pps_sync;
      end
      reg_irq_mask:   rd_data[num_evt-1:0] = irq_mask;
      reg_gpio:       rd_data[gpio_w-1:0] = gpio;
      reg_scratch:    rd_data = scratch;
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      wb_ack <= req.req_valid & req.req_hit;
      wb_err <= req.req_valid & ~req.req_hit;
    end
  end

  // Data only moves with a request
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wb_dat_r <= '0;
    end else if (req.req_valid) begin
      wb_dat_r <= req.req_hit ? rd_data : '0;
    end
  end

endmodule

// File: source/board_reg_decode.sv
/*
  Wishbone classic front end
  Turns each bus cycle into one registered register request
*/
module board_reg_decode (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  board_ctrl_pkg::reg_idx_t  wb_adr,
  input  logic [3:0]                wb_sel,
  input  logic [31:0]               wb_dat_w,
  board_req_if.decode               req
);
  import board_ctrl_pkg::*;

  logic        stb_q;
  logic        armed;
  logic        start;
  logic        we_q;
  reg_idx_t    adr_q;
  logic [3:0]  sel_q;
  logic [31:0] dat_q;

  // Input stage
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      stb_q <= 1'b0;
    end else begin
      stb_q <= wb_cyc & wb_stb;
    end
  end

  always_ff @(posedge bus_clk) begin
    we_q  <= wb_we;
    adr_q <= wb_adr;
    sel_q <= wb_sel;
    dat_q <= wb_dat_w;
  end

  // One request per strobe, rearm once strobe seen low
  assign start = stb_q & armed;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      armed         <= 1'b1;
      req.req_valid <= 1'b0;
    end else begin
      req.req_valid <= start;
      if (start) begin
        armed <= 1'b0;
      end else if (!stb_q) begin
        armed <= 1'b1;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (start) begin
      req.req_we    <= we_q;
      req.req_idx   <= adr_q;
      req.req_wdata <= dat_q;
      req.req_sel   <= sel_q;
      req.req_hit   <= (adr_q < reg_idx_t'(num_regs));
    end
  end

endmodule

// File: source/board_req_if.sv
/*
  Decoded register request
  One strobe per bus cycle from decode to execute and result
*/
interface board_req_if;
  import board_ctrl_pkg::*;

  logic        req_valid;
  logic        req_we;
  reg_idx_t    req_idx;
  logic [31:0] req_wdata;
  logic [3:0]  req_sel;
  // Index falls inside the register map
  logic        req_hit;

  modport decode (
    output req_valid, req_we, req_idx, req_wdata, req_sel, req_hit
  );

  modport exec (
    input req_valid, req_we, req_idx, req_wdata, req_sel, req_hit
  );

  modport result (
    input req_valid, req_we, req_idx, req_wdata, req_sel, req_hit
  );

endinterface
